/* iq_stream_packer.f */
+incdir+.
iq_stream_pkg.sv
iq_sample_format.sv
iq_burst_framer.sv
iq_stream_fifo.sv
iq_stream_packer.sv
iq_stream_packer_props.sv
tb_clock_gen.sv
tb_iq_stream_packer.sv

/* tb_iq_stream_packer.sv */
/*
 * I/Q stream packer testbench
 * lfsr stimulus, lane-order reference model, stream comparator and summary
 */

`timescale 1ns/1ps

`include "iq_stream_settings.svh"

module tb_iq_stream_packer;

  localparam int P     = `IQ_PRECISION;
  localparam int BL    = `IQ_BURST_LENGTH;
  localparam int DEPTH = `IQ_FIFO_DEPTH;
  // cycle budget of reset and of each test in turn
  localparam int BUDGET = 16 + 20 + 40 + 80 + 260 + 80;

  logic                    clk;
  logic                    rst_n;
  logic [3:0]              valid;
  logic [11:0]             di [4];
  logic [11:0]             dq [4];
  logic                    tready;
  logic                    tvalid;
  logic                    tlast;
  logic                    overflow;
  iq_stream_pkg::iq_beat_u tdata;

  // reference model state
  iq_stream_pkg::iq_beat_u exp_data [$];
  logic                    exp_last [$];
  iq_stream_pkg::iq_beat_u pend_beat;
  iq_stream_pkg::iq_beat_u exp_beat;
  logic                    pend_valid;
  logic                    exp_ovf;
  logic                    last_bit;
  int                      occ;
  int                      occ_start;
  int                      burst_pos;
  int                      errors;
  int                      checks;
  int                      ovf_seen;
  int                      xfers;
  int                      lasts;

  // stimulus scratch
  logic [15:0]             lfsr = 16'd51;
  logic [47:0]             r;
  logic [11:0]             ext [4] = '{12'h7ff, 12'h800, 12'h000, 12'hfff};
  int                      e0;
  int                      pos0;
  int                      lasts0;
  int                      ovf0;

  tb_clock_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  iq_stream_packer uut (
    .clk (clk), .rst_n (rst_n),
    .valid_0 (valid[0]), .data_i0 (di[0]), .data_q0 (dq[0]),
    .valid_1 (valid[1]), .data_i1 (di[1]), .data_q1 (dq[1]),
    .valid_2 (valid[2]), .data_i2 (di[2]), .data_q2 (dq[2]),
    .valid_3 (valid[3]), .data_i3 (di[3]), .data_q3 (dq[3]),
    .m_axis_tvalid (tvalid), .m_axis_tready (tready),
    .m_axis_tdata (tdata), .m_axis_tlast (tlast), .overflow (overflow)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // expected beat by lanes from the top P bits of each component
  function automatic iq_stream_pkg::iq_beat_u expected_beat();
    iq_stream_pkg::iq_beat_u b;
    for (int ch = 0; ch < 4; ch++) begin
      b.lanes[7 - 2 * ch] = di[ch][11 -: P];
      b.lanes[6 - 2 * ch] = dq[ch][11 -: P];
    end
    return b;
  endfunction

  // fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [47:0] random_bits(input int n);
    logic [47:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val  = {val[46:0], fb};
    end
    return val;
  endfunction

  task automatic check_value(input string name, input logic [95:0] got,
                             input logic [95:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // control 1 ns after the edge and the caller fills data in the same step
  task automatic drive(input logic [3:0] v, input logic rdy);
    @(posedge clk);
    #1;
    valid  = v;
    tready = rdy;
  endtask

  task automatic random_data();
    for (int ch = 0; ch < 4; ch++) begin
      r = random_bits(12);
      di[ch] = r[11:0];
      r = random_bits(12);
      dq[ch] = r[11:0];
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((occ != 0 || pend_valid || exp_ovf || exp_data.size() != 0) && n < 40) begin
      drive(4'h0, 1'b1);
      n++;
    end
    drive(4'h0, 1'b1);
    if (occ != 0) begin
      errors++;
      $display("stream did not drain within 40 cycles");
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    $display("test %-24s %s, %0d errors", name,
             (errors == err_before) ? "ok" : "FAILED", errors - err_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model and comparator sampled mid-cycle where all is settled
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      occ        = 0;
      burst_pos  = 0;
      pend_valid = 1'b0;
      exp_ovf    = 1'b0;
      exp_data.delete();
      exp_last.delete();
    end else begin
      check_value("overflow", overflow, exp_ovf);
      check_value("m_axis_tvalid", tvalid, occ != 0);
      if (overflow)
        ovf_seen++;
      if (!tvalid)
        check_value("m_axis_tlast", tlast, 1'b0);
      occ_start = occ;
      // transfer at the coming edge
      if (tvalid && tready) begin
        xfers++;
        if (tlast)
          lasts++;
        if (exp_data.size() == 0) begin
          errors++;
          $display("output beat with nothing expected");
        end else begin
          exp_beat = exp_data.pop_front();
          last_bit = exp_last.pop_front();
          check_value("m_axis_tdata", tdata, exp_beat);
          check_value("m_axis_tlast", tlast, last_bit);
        end
        if (occ > 0)
          occ--;
      end
      // formatter beat meets the fifo with room judged before this cycle's pop
      exp_ovf = 1'b0;
      if (pend_valid) begin
        if (occ_start < DEPTH) begin
          exp_data.push_back(pend_beat);
          exp_last.push_back(burst_pos == BL - 1);
          burst_pos = (burst_pos == BL - 1) ? 0 : burst_pos + 1;
          occ++;
        end else begin
          exp_ovf = 1'b1;
        end
      end
      pend_valid = |valid;
      if (pend_valid)
        pend_beat = expected_beat();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    valid  = 4'h0;
    tready = 1'b0;
    for (int ch = 0; ch < 4; ch++) begin
      di[ch] = '0;
      dq[ch] = '0;
    end
    errors   = 0;
    checks   = 0;
    ovf_seen = 0;
    xfers    = 0;
    lasts    = 0;
    wait (rst_n === 1'b1);

    e0 = errors;
    repeat (20) drive(4'h0, 1'b0);
    finish_test("idle after reset", e0);

    // full scale both ways, zero and minus one across all lanes
    e0 = errors;
    for (int b = 0; b < 20; b++) begin
      drive(4'hf, 1'b1);
      for (int ch = 0; ch < 4; ch++) begin
        di[ch] = ext[(b + 2 * ch) % 4];
        dq[ch] = ext[(b + 2 * ch + 1) % 4];
      end
    end
    drain();
    finish_test("extreme values", e0);

    e0     = errors;
    pos0   = xfers % BL;
    lasts0 = lasts;
    for (int b = 0; b < 48; b++) begin
      r = random_bits(2);
      drive(4'b0001 << r[1:0], 1'b1);
      random_data();
    end
    drain();
    check_value("tlast count", lasts - lasts0, (pos0 + 48) / BL - pos0 / BL);
    finish_test("single channel", e0);

    // tready high for 11 of 16 codes
    e0 = errors;
    for (int b = 0; b < 200; b++) begin
      r = random_bits(4);
      pos0 = r[3:0];
      r = random_bits(4);
      drive(pos0[3:0], r[3:0] < 11);
      random_data();
    end
    drain();
    finish_test("random valid and ready", e0);

    e0   = errors;
    ovf0 = ovf_seen;
    repeat (16) begin
      drive(4'hf, 1'b0);
      random_data();
    end
    repeat (3) drive(4'h0, 1'b0);
    check_value("overflow pulses", ovf_seen - ovf0, 16 - DEPTH);
    check_value("m_axis_tvalid", tvalid, 1'b1);
    drain();
    finish_test("overflow and drain", e0);

    if (uut.u_props.failures != 0) begin
      errors += uut.u_props.failures;
      $display("%0d assertion failures in the stream checker", uut.u_props.failures);
    end

    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // twice the summed cycle budgets
  initial begin
    #(BUDGET * 2 * 100);
    $display("watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

endmodule

/* tb_clock_gen.sv */
/*
 * testbench clock and reset, 100 ns period, reset low for 16 cycles
 */

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 50;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release just after an edge, same as the stimulus
  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

/* iq_stream_packer_props.sv */
/*
 * I/Q stream packer properties
 * stream hold rules, overflow cause and tlast qualification on the top level
 */

`timescale 1ns/1ps

module iq_stream_packer_props (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    m_axis_tvalid,
  input logic                    m_axis_tready,
  input iq_stream_pkg::iq_beat_u m_axis_tdata,
  input logic                    m_axis_tlast,
  input logic                    overflow,
  input logic                    full
);

  // count of failed assertions
  int failures = 0;

  // stalled beat stays put until taken
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else begin
      failures++;
      $error("stream beat changed while stalled");
    end

  // a drop needs a full fifo one cycle earlier
  a_ovf_cause: assert property (@(posedge clk) disable iff (!rst_n)
    overflow |-> $past(full))
    else begin
      failures++;
      $error("overflow pulse without full");
    end

  a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
    m_axis_tlast |-> m_axis_tvalid)
    else begin
      failures++;
      $error("tlast without tvalid");
    end

endmodule

// full is internal to the top and reached through the bind scope
bind iq_stream_packer iq_stream_packer_props u_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tlast  (m_axis_tlast),
  .overflow      (overflow),
  .full          (full)
);

/* iq_stream_packer.sv */
/*
 * I/Q stream packer top
 * formatter, burst framer and output fifo from four converter channels to a stream
 */

`timescale 1ns/1ps

module iq_stream_packer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    valid_0,
  input  logic [11:0]             data_i0,
  input  logic [11:0]             data_q0,
  input  logic                    valid_1,
  input  logic [11:0]             data_i1,
  input  logic [11:0]             data_q1,
  input  logic                    valid_2,
  input  logic [11:0]             data_i2,
  input  logic [11:0]             data_q2,
  input  logic                    valid_3,
  input  logic [11:0]             data_i3,
  input  logic [11:0]             data_q3,
  output logic                    m_axis_tvalid,
  input  logic                    m_axis_tready,
  output iq_stream_pkg::iq_beat_u m_axis_tdata,
  output logic                    m_axis_tlast,
  output logic                    overflow
);

  // formatter to framer
  logic                    samps_valid;
  iq_stream_pkg::iq_beat_u samps_data;

  // framer to fifo
  logic                    wr_en;
  iq_stream_pkg::iq_beat_u wr_data;
  logic                    wr_last;
  logic                    full;

  //////////////////////////////////////////////////////////////////////////////
  // pipeline
  //////////////////////////////////////////////////////////////////////////////

  iq_sample_format u_format (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_0     (valid_0),
    .data_i0     (data_i0),
    .data_q0     (data_q0),
    .valid_1     (valid_1),
    .data_i1     (data_i1),
    .data_q1     (data_q1),
    .valid_2     (valid_2),
    .data_i2     (data_i2),
    .data_q2     (data_q2),
    .valid_3     (valid_3),
    .data_i3     (data_i3),
    .data_q3     (data_q3),
    .samps_valid (samps_valid),
    .samps_data  (samps_data)
  );

  // combinational write path, registered overflow
  iq_burst_framer u_framer (
    .clk         (clk),
    .rst_n       (rst_n),
    .samps_valid (samps_valid),
    .samps_data  (samps_data),
    .full        (full),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .wr_last     (wr_last),
    .overflow    (overflow)
  );

  iq_stream_fifo u_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_en         (wr_en),
    .wr_data       (wr_data),
    .wr_last       (wr_last),
    .full          (full),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule

/* iq_stream_fifo.sv */
/*
 * I/Q stream output FIFO
 * synchronous first-word-fall-through buffer in front of the stream master
 */

`timescale 1ns/1ps

`include "iq_stream_settings.svh"

module iq_stream_fifo (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wr_en,
  input  iq_stream_pkg::iq_beat_u wr_data,
  input  logic                    wr_last,
  output logic                    full,
  output logic                    m_axis_tvalid,
  input  logic                    m_axis_tready,
  output iq_stream_pkg::iq_beat_u m_axis_tdata,
  output logic                    m_axis_tlast
);

  // address bits, pointers carry one extra wrap bit
  localparam int AW = $clog2(`IQ_FIFO_DEPTH);

  iq_stream_pkg::iq_beat_u data_mem [`IQ_FIFO_DEPTH];
  logic                    last_mem [`IQ_FIFO_DEPTH];

  logic [AW:0]   wr_ptr;
  logic [AW:0]   rd_ptr;
  logic [AW-1:0] wr_addr;
  logic [AW-1:0] rd_addr;
  logic          empty;
  logic          rd_en;

  ////////////////////////////////////////////////////////////////////////////
  // pointers and status
  ////////////////////////////////////////////////////////////////////////////

  assign wr_addr = wr_ptr[AW-1:0];
  assign rd_addr = rd_ptr[AW-1:0];

  // same address, wrap bits differ when full
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_addr == rd_addr);

  // handshake on the head entry
  assign rd_en = m_axis_tvalid & m_axis_tready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  // framer never writes while full, so no overwrite of unread entries
  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[wr_addr] <= wr_data;
      last_mem[wr_addr] <= wr_last;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stream master
  ////////////////////////////////////////////////////////////////////////////

  // head entry shown directly
  // held until the pop since rd_ptr only moves on a transfer
  assign m_axis_tvalid = ~empty;
  assign m_axis_tdata  = data_mem[rd_addr];

  // empty slots may hold stale flags
  assign m_axis_tlast  = ~empty & last_mem[rd_addr];

endmodule

/* iq_burst_framer.sv */
/*
 * I/Q burst framer
 * writes beats into the fifo when room, marks each burst end, flags drops
 */

`timescale 1ns/1ps

`include "iq_stream_settings.svh"

module iq_burst_framer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    samps_valid,
  input  iq_stream_pkg::iq_beat_u samps_data,
  input  logic                    full,
  output logic                    wr_en,
  output iq_stream_pkg::iq_beat_u wr_data,
  output logic                    wr_last,
  output logic                    overflow
);

  // position counter width, at least one bit
  localparam int CW = (`IQ_BURST_LENGTH > 1) ? $clog2(`IQ_BURST_LENGTH) : 1;

  logic [CW-1:0] burst_pos;
  logic          at_end;
  logic          drop;

  ////////////////////////////////////////////////////////////////////////////
  // write gating
  ////////////////////////////////////////////////////////////////////////////

  // source cannot stall, a beat meeting a full fifo is lost
  assign wr_en   = samps_valid & ~full;
  assign drop    = samps_valid & full;
  assign wr_data = samps_data;

  // final beat of the burst
  assign at_end  = (burst_pos == CW'(`IQ_BURST_LENGTH - 1));
  assign wr_last = wr_en & at_end;

  // counts written beats only, dropped ones hold the position
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      burst_pos <= '0;
    end else if (wr_en) begin
      burst_pos <= at_end ? '0 : burst_pos + 1'b1;
    end
  end

  // one pulse per lost beat, a cycle late
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else begin
      overflow <= drop;
    end
  end

endmodule

/* iq_sample_format.sv */
/*
 * I/Q sample formatter
 * cuts four channels of 12-bit i/q to the packed precision, registers one beat
 */

`timescale 1ns/1ps

`include "iq_stream_settings.svh"

module iq_sample_format (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    valid_0,
  input  logic [11:0]             data_i0,
  input  logic [11:0]             data_q0,
  input  logic                    valid_1,
  input  logic [11:0]             data_i1,
  input  logic [11:0]             data_q1,
  input  logic                    valid_2,
  input  logic [11:0]             data_i2,
  input  logic [11:0]             data_q2,
  input  logic                    valid_3,
  input  logic [11:0]             data_i3,
  input  logic [11:0]             data_q3,
  output logic                    samps_valid,
  output iq_stream_pkg::iq_beat_u samps_data
);

  // lsbs dropped per component
  localparam int REDUCE = 12 - `IQ_PRECISION;

  logic signed [11:0]      raw_i [4];
  logic signed [11:0]      raw_q [4];
  logic                    any_valid;
  iq_stream_pkg::iq_beat_u beat_next;

  // keep the msbs, sign carried down by the arithmetic shift
  function automatic iq_stream_pkg::iq_lane_t reduce(input logic signed [11:0] comp);
    logic signed [11:0] shifted;
    shifted = comp >>> REDUCE;
    return shifted[`IQ_PRECISION-1:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  // channel index order
  assign raw_i[0] = data_i0;
  assign raw_q[0] = data_q0;
  assign raw_i[1] = data_i1;
  assign raw_q[1] = data_q1;
  assign raw_i[2] = data_i2;
  assign raw_q[2] = data_q2;
  assign raw_i[3] = data_i3;
  assign raw_q[3] = data_q3;

  // one valid channel is enough for a whole beat
  assign any_valid = valid_0 | valid_1 | valid_2 | valid_3;

  // channel 0 lands in the top pair
  always_comb begin
    for (int ch = 0; ch < 4; ch++) begin
      beat_next.pairs[ch].i = reduce(raw_i[ch]);
      beat_next.pairs[ch].q = reduce(raw_q[ch]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register, one cycle
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      samps_valid <= 1'b0;
    end else begin
      samps_valid <= any_valid;
    end
  end

  // payload only, follows the inputs every cycle
  always_ff @(posedge clk) begin
    samps_data <= beat_next;
  end

endmodule

/* iq_stream_pkg.sv */
/*
 * I/Q stream packer types
 * one stream beat, viewed either as eight lanes or as four channel pairs
 */

`include "iq_stream_settings.svh"

package iq_stream_pkg;

  // one reduced component
  typedef logic [`IQ_PRECISION-1:0] iq_lane_t;

  // one channel, i in the upper half
  typedef struct packed {
    iq_lane_t i;
    iq_lane_t q;
  } iq_pair_t;

  //////////////////////////////////////////////////////////////////////////
  // stream beat
  //////////////////////////////////////////////////////////////////////////

  // lanes view: lane 7 = i0, lane 6 = q0 ... lane 0 = q3
  // pairs view: pair 0 in the top bits = channel 0 ... pair 3 = channel 3
  // both views cover the same 8 * precision bits
  typedef union packed {
    iq_lane_t [7:0] lanes;
    iq_pair_t [0:3] pairs;
  } iq_beat_u;

endpackage

/* iq_stream_settings.svh */
/*
 * I/Q stream packer build settings
 * precision per component, burst framing length and output FIFO depth
 */

`ifndef IQ_STREAM_SETTINGS_SVH
`define IQ_STREAM_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////////////
// sample format
//////////////////////////////////////////////////////////////////////////////

// bits kept per component, msbs of the 12-bit converter word (1 to 12)
`define IQ_PRECISION 10

//////////////////////////////////////////////////////////////////////////////
// framing and buffering
//////////////////////////////////////////////////////////////////////////////

// accepted beats per burst, tlast on the final one
`define IQ_BURST_LENGTH 16

// output fifo entries, power of two, at least 2
`define IQ_FIFO_DEPTH 8

`endif
